/* source/cam_link_pkg.sv */
// Shared widths, bus structs and state encodings for the UART image link
// Addresses are pixel indices into the frame store, one byte per pixel
`default_nettype none

package cam_link_pkg;

  // ============================================================
  // Widths and constants
  // ============================================================
  localparam int BYTE_W = 8;
  localparam int ADDR_W = 23;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Start of the stored-image area, the live frame sits at zero
  localparam addr_t STORED_BASE = 23'h100000;

  // ============================================================
  // Bundles
  // ============================================================
  typedef struct packed {
    byte_t data;
    logic  valid;
  } rx_byte_t;

  // Wishbone classic, read-only use in this design
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    byte_t dat;
  } wb_rsp_t;

  // Active low, bit 6 is segment g
  typedef logic [6:0] seg_t;

  typedef struct packed {
    seg_t hex5;
    seg_t hex4;
    seg_t hex3;
    seg_t hex2;
    seg_t hex1;
    seg_t hex0;
  } hex_digits_t;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  typedef enum logic [1:0] {
    DUMP_IDLE,
    DUMP_READ,
    DUMP_SEND,
    DUMP_WAIT_DONE
  } dump_state_e;

endpackage

`default_nettype wire

/* source/uart_rx.sv */
// 8N1 receiver, no parity, one byte per frame with a high stop bit
// CLKS_PER_BIT must be at least 4 for the mid-bit sampling to work
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire logic                  CLOCK_50,
  input  wire logic                  DLY_RST_0,
  input  wire logic                  rxd,
  output cam_link_pkg::rx_byte_t     rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  cam_link_pkg::uart_state_e state_q;
  logic [CNT_W-1:0]          cnt_q;
  logic [2:0]                bit_idx_q;
  logic [2:0]                rx_sr_q;
  cam_link_pkg::byte_t       shift_q;
  cam_link_pkg::byte_t       data_q;
  logic                      valid_q;

  logic rx_line;
  logic start_edge;
  logic bit_tick;

  // Two sync flops, third one keeps the previous level for the edge
  assign rx_line    = rx_sr_q[1];
  assign start_edge = rx_sr_q[2] & ~rx_sr_q[1];
  assign bit_tick   = (cnt_q == BIT_LAST);

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rx_sr_q   <= 3'b111;
      state_q   <= cam_link_pkg::UART_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      data_q    <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_sr_q <= {rx_sr_q[1:0], rxd};
      valid_q <= 1'b0;
      case (state_q)
        cam_link_pkg::UART_IDLE: begin
          cnt_q <= '0;
          if (start_edge) begin
            state_q <= cam_link_pkg::UART_START;
          end
        end
        cam_link_pkg::UART_START: begin
          // Recheck the line half a bit in, glitches go back to idle
          if (cnt_q == HALF_LAST) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_line ? cam_link_pkg::UART_IDLE : cam_link_pkg::UART_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        cam_link_pkg::UART_DATA: begin
          if (bit_tick) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              state_q <= cam_link_pkg::UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // Mid stop bit, a low line here is a framing error
          if (bit_tick) begin
            state_q <= cam_link_pkg::UART_IDLE;
            if (rx_line) begin
              data_q  <= shift_q;
              valid_q <= 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (state_q == cam_link_pkg::UART_DATA && bit_tick) begin
      shift_q <= {rx_line, shift_q[7:1]};
    end
  end

  assign rx_byte.data  = data_q;
  assign rx_byte.valid = valid_q;

endmodule

`default_nettype wire

/* source/uart_tx.sv */
// 8N1 transmitter, LSB first, line idles high
// tx_start is only taken while tx_busy is low
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire logic                CLOCK_50,
  input  wire logic                DLY_RST_0,
  input  wire logic                tx_start,
  input  wire cam_link_pkg::byte_t tx_data,
  output logic                     txd,
  output logic                     tx_busy,
  output logic                     tx_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  cam_link_pkg::uart_state_e state_q;
  logic [CNT_W-1:0]          cnt_q;
  logic [2:0]                bit_idx_q;
  cam_link_pkg::byte_t       data_q;
  logic                      txd_q;
  logic                      done_q;
  logic                      bit_tick;

  assign bit_tick = (cnt_q == BIT_LAST);

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state_q   <= cam_link_pkg::UART_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      txd_q     <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        cam_link_pkg::UART_IDLE: begin
          cnt_q <= '0;
          if (tx_start) begin
            txd_q   <= 1'b0;
            state_q <= cam_link_pkg::UART_START;
          end
        end
        cam_link_pkg::UART_START: begin
          if (bit_tick) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            txd_q     <= data_q[0];
            state_q   <= cam_link_pkg::UART_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        cam_link_pkg::UART_DATA: begin
          if (bit_tick) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              txd_q   <= 1'b1;
              state_q <= cam_link_pkg::UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
              txd_q     <= data_q[bit_idx_q + 3'd1];
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (bit_tick) begin
            done_q  <= 1'b1;
            state_q <= cam_link_pkg::UART_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (state_q == cam_link_pkg::UART_IDLE && tx_start) begin
      data_q <= tx_data;
    end
  end

  assign txd     = txd_q;
  assign tx_busy = (state_q != cam_link_pkg::UART_IDLE);
  assign tx_done = done_q;

  // Dump engine must respect back-pressure
  assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    tx_start |-> !tx_busy)
    else $error("tx_start raised while transmitter busy");

endmodule

`default_nettype wire

/* source/image_select.sv */
// Image index register and frame read base for the display side
// Base wraps at 23 bits if index times FRAME_PIXELS runs past the store
`timescale 1ns/10ps
`default_nettype none

module image_select #(
  parameter int FRAME_PIXELS = 307200
) (
  input  wire logic                   CLOCK_50,
  input  wire logic                   DLY_RST_0,
  input  wire cam_link_pkg::rx_byte_t rx_byte,
  input  wire logic                   sw_store,
  input  wire logic                   sw_live,
  output cam_link_pkg::byte_t         cur_img,
  output cam_link_pkg::addr_t         read_base,
  output logic                        disp_rst_n
);

  cam_link_pkg::byte_t img_q;
  cam_link_pkg::byte_t img_prev_q;
  logic                live_q;
  logic                live_prev_q;
  logic                rst_n_q;
  logic                disp_changed;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      img_q       <= '0;
      img_prev_q  <= '0;
      live_q      <= 1'b0;
      live_prev_q <= 1'b0;
      rst_n_q     <= 1'b1;
    end else begin
      // Bytes only select an image while not storing
      if (rx_byte.valid && !sw_store) begin
        img_q <= rx_byte.data;
      end
      live_q      <= sw_live;
      img_prev_q  <= img_q;
      live_prev_q <= live_q;
      rst_n_q     <= !disp_changed;
    end
  end

  assign disp_changed = (img_q != img_prev_q) || (live_q != live_prev_q);

  // Live camera frame at zero, stored images packed after STORED_BASE
  assign read_base = live_q ? '0 :
    cam_link_pkg::STORED_BASE +
    cam_link_pkg::addr_t'(img_q) * cam_link_pkg::addr_t'(FRAME_PIXELS);

  assign cur_img    = img_q;
  assign disp_rst_n = rst_n_q;

  // Restart pulse is a single cycle wide
  assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    !disp_rst_n |=> disp_rst_n)
    else $error("disp_rst_n low for more than one cycle");

endmodule

`default_nettype wire

/* source/frame_buffer.sv */
// On-chip pixel store standing in for the SDRAM frame area
// Writes follow a wrapping pointer, reads go through Wishbone classic
`timescale 1ns/10ps
`default_nettype none

module frame_buffer #(
  parameter int FRAME_PIXELS = 307200
) (
  input  wire logic                   CLOCK_50,
  input  wire logic                   DLY_RST_0,
  input  wire cam_link_pkg::rx_byte_t rx_byte,
  input  wire logic                   sw_store,
  input  wire cam_link_pkg::wb_req_t  wb_req,
  output cam_link_pkg::wb_rsp_t       wb_rsp
);

  localparam int PTR_W = $clog2(FRAME_PIXELS);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FRAME_PIXELS - 1);

  cam_link_pkg::byte_t mem [FRAME_PIXELS];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic                ack_q;
  cam_link_pkg::byte_t dat_q;
  logic                rd_req;

  assign rd_req = wb_req.cyc & wb_req.stb & ~wb_req.we;

  // ============================================================
  // Store path
  // ============================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      wr_ptr_q <= '0;
    end else if (rx_byte.valid && sw_store) begin
      wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (rx_byte.valid && sw_store) begin
      mem[wr_ptr_q] <= rx_byte.data;
    end
  end

  // ============================================================
  // Read slave, ack one cycle after stb, never twice in a row
  // ============================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= rd_req & ~ack_q;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    dat_q <= mem[PTR_W'(wb_req.adr)];
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

  assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    wb_rsp.ack |-> wb_req.stb)
    else $error("ack without stb");

endmodule

`default_nettype wire

/* source/frame_dump.sv */
// Streams FRAME_PIXELS stored bytes out over the UART on a key press
// Keys are active low and synchronized here, abort beats dump
`timescale 1ns/10ps
`default_nettype none

module frame_dump #(
  parameter int FRAME_PIXELS = 307200
) (
  input  wire logic                  CLOCK_50,
  input  wire logic                  DLY_RST_0,
  input  wire logic                  key_dump_n,
  input  wire logic                  key_abort_n,
  input  wire cam_link_pkg::wb_rsp_t wb_rsp,
  input  wire logic                  tx_busy,
  input  wire logic                  tx_done,
  output cam_link_pkg::wb_req_t      wb_req,
  output logic                       tx_start,
  output cam_link_pkg::byte_t        tx_data,
  output logic                       dump_active
);

  localparam int CNT_W = $clog2(FRAME_PIXELS + 1);
  localparam logic [CNT_W-1:0] FRAME_CNT = CNT_W'(FRAME_PIXELS);

  cam_link_pkg::dump_state_e state_q;
  logic [2:0]                dump_sr_q;
  logic [2:0]                abort_sr_q;
  logic [CNT_W-1:0]          count_q;
  cam_link_pkg::addr_t       adr_q;
  cam_link_pkg::byte_t       pix_q;
  logic                      active_q;
  logic                      req_q;
  logic                      start_q;

  logic dump_press;
  logic abort_press;
  logic pix_done;

  // Falling edge after two sync flops
  assign dump_press  = dump_sr_q[2] & ~dump_sr_q[1];
  assign abort_press = abort_sr_q[2] & ~abort_sr_q[1];
  assign pix_done    = (state_q == cam_link_pkg::DUMP_WAIT_DONE) && tx_done;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      dump_sr_q  <= 3'b111;
      abort_sr_q <= 3'b111;
      active_q   <= 1'b0;
      count_q    <= '0;
    end else begin
      dump_sr_q  <= {dump_sr_q[1:0], key_dump_n};
      abort_sr_q <= {abort_sr_q[1:0], key_abort_n};
      if (abort_press) begin
        active_q <= 1'b0;
      end else if (dump_press) begin
        active_q <= 1'b1;
      end else if (state_q == cam_link_pkg::DUMP_IDLE && count_q == FRAME_CNT) begin
        active_q <= 1'b0;
      end
      if (dump_press && !abort_press) begin
        count_q <= '0;
      end else if (pix_done) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // ============================================================
  // Per-pixel sequence: bus read, serial send, wait for done
  // ============================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state_q <= cam_link_pkg::DUMP_IDLE;
      req_q   <= 1'b0;
      adr_q   <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        cam_link_pkg::DUMP_IDLE: begin
          if (active_q && !abort_press && !dump_press && count_q != FRAME_CNT) begin
            req_q   <= 1'b1;
            adr_q   <= cam_link_pkg::addr_t'(count_q);
            state_q <= cam_link_pkg::DUMP_READ;
          end
        end
        cam_link_pkg::DUMP_READ: begin
          // An abort during the read drops the pixel unsent
          if (wb_rsp.ack) begin
            req_q   <= 1'b0;
            state_q <= active_q ? cam_link_pkg::DUMP_SEND : cam_link_pkg::DUMP_IDLE;
          end
        end
        cam_link_pkg::DUMP_SEND: begin
          if (!tx_busy) begin
            start_q <= 1'b1;
            state_q <= cam_link_pkg::DUMP_WAIT_DONE;
          end
        end
        default: begin
          if (tx_done) begin
            state_q <= cam_link_pkg::DUMP_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (state_q == cam_link_pkg::DUMP_READ && wb_rsp.ack) begin
      pix_q <= wb_rsp.dat;
    end
  end

  assign wb_req.cyc  = req_q;
  assign wb_req.stb  = req_q;
  assign wb_req.we   = 1'b0;
  assign wb_req.adr  = adr_q;
  assign tx_start    = start_q;
  assign tx_data     = pix_q;
  assign dump_active = active_q;

  // Classic cycle, stb held until the slave answers in the next cycle
  assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    wb_req.stb && !wb_rsp.ack |=> wb_req.stb && wb_rsp.ack)
    else $error("stb dropped or ack missing in the cycle after stb");

endmodule

`default_nettype wire

/* source/hex_status.sv */
// Six active-low seven-segment digits, registered
// hex1:0 image index, hex3:2 last byte, hex4 dump flag, hex5 blank zero
`timescale 1ns/10ps
`default_nettype none

module hex_status (
  input  wire logic                   CLOCK_50,
  input  wire logic                   DLY_RST_0,
  input  wire cam_link_pkg::byte_t    cur_img,
  input  wire cam_link_pkg::rx_byte_t rx_byte,
  input  wire logic                   dump_active,
  output cam_link_pkg::hex_digits_t   hex
);

  cam_link_pkg::byte_t       last_q;
  cam_link_pkg::hex_digits_t hex_q;

  // Segment g down to a, low lights the segment
  function automatic cam_link_pkg::seg_t seg_of(input logic [3:0] nib);
    case (nib)
      4'h0:    seg_of = 7'h40;
      4'h1:    seg_of = 7'h79;
      4'h2:    seg_of = 7'h24;
      4'h3:    seg_of = 7'h30;
      4'h4:    seg_of = 7'h19;
      4'h5:    seg_of = 7'h12;
      4'h6:    seg_of = 7'h02;
      4'h7:    seg_of = 7'h78;
      4'h8:    seg_of = 7'h00;
      4'h9:    seg_of = 7'h10;
      4'hA:    seg_of = 7'h08;
      4'hB:    seg_of = 7'h03;
      4'hC:    seg_of = 7'h46;
      4'hD:    seg_of = 7'h21;
      4'hE:    seg_of = 7'h06;
      default: seg_of = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      last_q <= '0;
      hex_q  <= '1;
    end else begin
      if (rx_byte.valid) begin
        last_q <= rx_byte.data;
      end
      hex_q.hex5 <= seg_of(4'h0);
      hex_q.hex4 <= seg_of({3'b000, dump_active});
      hex_q.hex3 <= seg_of(last_q[7:4]);
      hex_q.hex2 <= seg_of(last_q[3:0]);
      hex_q.hex1 <= seg_of(cur_img[7:4]);
      hex_q.hex0 <= seg_of(cur_img[3:0]);
    end
  end

  assign hex = hex_q;

endmodule

`default_nettype wire

/* source/cam_link_top.sv */
// UART image select and frame dump side of the camera board
// Defaults give 115200 baud at 50 MHz and a 640x480 frame
`timescale 1ns/10ps
`default_nettype none

module cam_link_top #(
  parameter int CLKS_PER_BIT = 434,
  parameter int FRAME_PIXELS = 307200
) (
  input  wire logic                 CLOCK_50,
  input  wire logic                 DLY_RST_0,
  input  wire logic                 uart_rxd,
  input  wire logic                 sw_store,
  input  wire logic                 sw_live,
  input  wire logic                 key_dump_n,
  input  wire logic                 key_abort_n,
  output logic                      uart_txd,
  output cam_link_pkg::addr_t       read_base,
  output logic                      disp_rst_n,
  output logic                      dump_active,
  output cam_link_pkg::hex_digits_t hex
);

  cam_link_pkg::rx_byte_t rx_byte;
  cam_link_pkg::wb_req_t  wb_req;
  cam_link_pkg::wb_rsp_t  wb_rsp;
  cam_link_pkg::byte_t    cur_img;
  cam_link_pkg::byte_t    tx_data;
  logic                   tx_start;
  logic                   tx_busy;
  logic                   tx_done;

  // ============================================================
  // Host link and image selection
  // ============================================================
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rxd       (uart_rxd),
    .rx_byte   (rx_byte)
  );

  image_select #(.FRAME_PIXELS(FRAME_PIXELS)) sel_i (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .rx_byte    (rx_byte),
    .sw_store   (sw_store),
    .sw_live    (sw_live),
    .cur_img    (cur_img),
    .read_base  (read_base),
    .disp_rst_n (disp_rst_n)
  );

  // ============================================================
  // Frame store and dump path
  // ============================================================
  frame_buffer #(.FRAME_PIXELS(FRAME_PIXELS)) fb_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rx_byte   (rx_byte),
    .sw_store  (sw_store),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp)
  );

  frame_dump #(.FRAME_PIXELS(FRAME_PIXELS)) dump_i (
    .CLOCK_50    (CLOCK_50),
    .DLY_RST_0   (DLY_RST_0),
    .key_dump_n  (key_dump_n),
    .key_abort_n (key_abort_n),
    .wb_rsp      (wb_rsp),
    .tx_busy     (tx_busy),
    .tx_done     (tx_done),
    .wb_req      (wb_req),
    .tx_start    (tx_start),
    .tx_data     (tx_data),
    .dump_active (dump_active)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_i (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .txd       (uart_txd),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done)
  );

  hex_status hex_i (
    .CLOCK_50    (CLOCK_50),
    .DLY_RST_0   (DLY_RST_0),
    .cur_img     (cur_img),
    .rx_byte     (rx_byte),
    .dump_active (dump_active),
    .hex         (hex)
  );

endmodule

`default_nettype wire

/* testbench/tb_cam_link.sv */
// Testbench for cam_link_top with an 8-clock bit time and a 16-pixel frame
// Host bytes and the dump stream are 8N1, decoded at mid-bit on the falling clock
`timescale 1ns/10ps
`default_nettype none

module tb_cam_link;

  localparam int CLKS_PER_BIT = 8;
  localparam int FRAME_PIXELS = 16;
  localparam int BYTE_CLKS    = 10 * CLKS_PER_BIT;
  localparam int WATCHDOG_NS  = 40 * 10 * CLKS_PER_BIT * 100 * 2;
  localparam logic [31:0] RAND_SEED = 32'hb028_95e3;

  // Digit fields inside the 42-bit hex bundle
  localparam logic [41:0] IMG_LAST_MASK = 42'h0000fffffff;
  localparam logic [41:0] LAST_MASK     = 42'h0000fffc000;
  localparam logic [41:0] HEX4_MASK     = 42'h007f0000000;

  // Active-low segments g..a for the hex digits 0 to F
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic                      CLOCK_50;
  logic                      DLY_RST_0;
  logic                      uart_rxd;
  logic                      sw_store;
  logic                      sw_live;
  logic                      key_dump_n;
  logic                      key_abort_n;
  logic                      uart_txd;
  cam_link_pkg::addr_t       read_base;
  logic                      disp_rst_n;
  logic                      dump_active;
  cam_link_pkg::hex_digits_t hex;
  logic [41:0]               hex_bits;

  cam_link_pkg::byte_t stored [FRAME_PIXELS];
  cam_link_pkg::byte_t tx_bytes [$];
  cam_link_pkg::byte_t img_model;
  cam_link_pkg::byte_t last_model;
  int                  checks;
  int                  errors;
  int                  test_errors;
  int                  restarts = 0;
  logic                in_store;
  logic                line_quiet;

  assign hex_bits = hex;

  cam_link_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FRAME_PIXELS (FRAME_PIXELS)
  ) dut_i (
    .CLOCK_50    (CLOCK_50),
    .DLY_RST_0   (DLY_RST_0),
    .uart_rxd    (uart_rxd),
    .sw_store    (sw_store),
    .sw_live     (sw_live),
    .key_dump_n  (key_dump_n),
    .key_abort_n (key_abort_n),
    .uart_txd    (uart_txd),
    .read_base   (read_base),
    .disp_rst_n  (disp_rst_n),
    .dump_active (dump_active),
    .hex         (hex)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #50 CLOCK_50 = ~CLOCK_50;
  end

  // Every low cycle of the restart line is one pulse
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0 && !disp_rst_n) begin
      restarts <= restarts + 1;
    end
  end

  assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0) in_store |-> disp_rst_n)
    else flag_error("display restart pulse while storing");

  assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0) line_quiet |-> uart_txd)
    else flag_error("uart_txd left idle after the abort");

  // ============================================================
  // Helpers
  // ============================================================
  task automatic flag_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_eq(input string name, input logic [41:0] got, input logic [41:0] exp);
    checks++;
    assert (got === exp)
    else begin
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  function automatic logic [13:0] byte_digits(input cam_link_pkg::byte_t b);
    return {SEG_TABLE[b[7:4]], SEG_TABLE[b[3:0]]};
  endfunction

  // Random byte that differs from the one shown last
  function automatic cam_link_pkg::byte_t fresh_byte(input cam_link_pkg::byte_t prev);
    cam_link_pkg::byte_t b;
    b = 8'($urandom);
    if (b == prev) begin
      b = b ^ 8'h5a;
    end
    return b;
  endfunction

  // Stored images sit 16 pixels apart above the stored base
  function automatic cam_link_pkg::addr_t base_of(input cam_link_pkg::byte_t img);
    return cam_link_pkg::STORED_BASE + {11'd0, img, 4'd0};
  endfunction

  task automatic drive_bit(input logic b);
    uart_rxd <= b;
    repeat (CLKS_PER_BIT) @(posedge CLOCK_50);
  endtask

  task automatic send_byte(input cam_link_pkg::byte_t b);
    @(posedge CLOCK_50);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
  endtask

  task automatic wait_digits(input logic [41:0] mask, input logic [41:0] exp, input string what);
    int n;
    n = 0;
    while (((hex_bits & mask) !== exp) && n < 4 * CLKS_PER_BIT) begin
      @(negedge CLOCK_50);
      n++;
    end
    checks++;
    if ((hex_bits & mask) !== exp) begin
      flag_error($sformatf("digits never showed %s", what));
    end
  endtask

  task automatic wait_dump(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (dump_active !== level && n < max_cycles) begin
      @(negedge CLOCK_50);
      n++;
    end
    checks++;
    if (dump_active !== level) begin
      flag_error(level ? "dump_active never rose" : "dump_active never fell");
    end
  endtask

  task automatic wait_tx_bytes(input int count, input int max_cycles);
    int n;
    n = 0;
    while (tx_bytes.size() < count && n < max_cycles) begin
      @(negedge CLOCK_50);
      n++;
    end
    checks++;
    if (tx_bytes.size() < count) begin
      flag_error("no byte came out on uart_txd");
    end
  endtask

  // ============================================================
  // Serial decoder on uart_txd, samples at mid-bit
  // ============================================================
  initial begin : tx_decoder
    cam_link_pkg::byte_t b;
    forever begin
      @(negedge CLOCK_50);
      if (DLY_RST_0 === 1'b1 && uart_txd === 1'b0) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge CLOCK_50);
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
          b[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
        if (uart_txd !== 1'b1) begin
          flag_error("stop bit low on uart_txd");
        end else begin
          tx_bytes.push_back(b);
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin : main
    int                  start_restarts;
    cam_link_pkg::byte_t b;
    DLY_RST_0   = 1'b0;
    uart_rxd    = 1'b1;
    sw_store    = 1'b0;
    sw_live     = 1'b0;
    key_dump_n  = 1'b1;
    key_abort_n = 1'b1;
    in_store    = 1'b0;
    line_quiet  = 1'b0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    img_model   = '0;
    last_model  = '0;
    void'($urandom(RAND_SEED));
    repeat (2) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;
    @(negedge CLOCK_50);

    check_eq("disp_rst_n", disp_rst_n, 1);
    check_eq("dump_active", dump_active, 0);
    check_eq("uart_txd", uart_txd, 1);
    check_eq("read_base", read_base, cam_link_pkg::STORED_BASE);
    end_test("reset");

    for (int k = 0; k < 3; k++) begin
      b = fresh_byte(last_model);
      start_restarts = restarts;
      send_byte(b);
      img_model  = b;
      last_model = b;
      wait_digits(IMG_LAST_MASK, 42'({byte_digits(b), byte_digits(b)}), "the selected image");
      repeat (3) @(negedge CLOCK_50);
      check_eq("read_base", read_base, base_of(img_model));
      check_eq("restart pulses", restarts - start_restarts, 1);
    end
    check_eq("hex4", hex.hex4, SEG_TABLE[0]);
    check_eq("hex5", hex.hex5, SEG_TABLE[0]);
    end_test("select");

    start_restarts = restarts;
    @(posedge CLOCK_50);
    sw_live <= 1'b1;
    repeat (4) @(negedge CLOCK_50);
    check_eq("read_base", read_base, 0);
    check_eq("restart pulses", restarts - start_restarts, 1);
    @(posedge CLOCK_50);
    sw_live <= 1'b0;
    repeat (4) @(negedge CLOCK_50);
    check_eq("read_base", read_base, base_of(img_model));
    check_eq("restart pulses", restarts - start_restarts, 2);
    end_test("live");

    @(posedge CLOCK_50);
    sw_store <= 1'b1;
    @(negedge CLOCK_50);
    in_store = 1'b1;
    start_restarts = restarts;
    for (int k = 0; k < FRAME_PIXELS; k++) begin
      b = fresh_byte(last_model);
      stored[k]  = b;
      last_model = b;
      send_byte(b);
      wait_digits(LAST_MASK, 42'({byte_digits(b), 14'b0}), "the stored byte");
    end
    repeat (3) @(negedge CLOCK_50);
    check_eq("image digits", hex_bits[13:0], byte_digits(img_model));
    check_eq("restart pulses", restarts - start_restarts, 0);
    in_store = 1'b0;
    end_test("store");

    tx_bytes.delete();
    @(posedge CLOCK_50);
    key_dump_n <= 1'b0;
    wait_dump(1'b1, 4);
    wait_digits(HEX4_MASK, 42'(SEG_TABLE[1]) << 28, "the dump flag");
    @(posedge CLOCK_50);
    key_dump_n <= 1'b1;
    wait_dump(1'b0, FRAME_PIXELS * (BYTE_CLKS + 10));
    check_eq("dumped byte count", tx_bytes.size(), FRAME_PIXELS);
    for (int k = 0; k < FRAME_PIXELS && k < tx_bytes.size(); k++) begin
      check_eq("uart_txd byte", tx_bytes[k], stored[k]);
    end
    end_test("dump");

    // Abort right after the first byte, one more may already be underway
    tx_bytes.delete();
    @(posedge CLOCK_50);
    key_dump_n <= 1'b0;
    wait_dump(1'b1, 4);
    @(posedge CLOCK_50);
    key_dump_n <= 1'b1;
    wait_tx_bytes(1, 2 * BYTE_CLKS);
    @(posedge CLOCK_50);
    key_abort_n <= 1'b0;
    wait_dump(1'b0, 4);
    @(posedge CLOCK_50);
    key_abort_n <= 1'b1;
    repeat (2 * BYTE_CLKS) @(negedge CLOCK_50);
    line_quiet = 1'b1;
    checks++;
    if (tx_bytes.size() > 2) begin
      flag_error("more than one byte went out after the abort");
    end
    if (tx_bytes.size() > 0) begin
      check_eq("uart_txd byte", tx_bytes[0], stored[0]);
    end
    repeat (BYTE_CLKS) @(negedge CLOCK_50);
    line_quiet = 1'b0;
    end_test("abort");

    $display("Checks run %0d, failed %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
source/cam_link_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/image_select.sv
source/frame_buffer.sv
source/frame_dump.sv
source/hex_status.sv
source/cam_link_top.sv
testbench/tb_cam_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cam_link -f build.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
